// ==== rtl/fabric_pkg.sv ====
package fabric_pkg;

   localparam int NUM_CLB     = 2;
   localparam int NUM_PAD_IN  = 4;
   localparam int NUM_PAD_OUT = 2;

   // X and Y for each block.
   localparam int NUM_CLB_OUT = 2 * NUM_CLB;

   // Pads first, then X0, Y0, X1, Y1.
   localparam int NUM_SRC     = NUM_PAD_IN + NUM_CLB_OUT;

   // Index into the routing source vector.
   typedef logic [$clog2(NUM_SRC)-1:0]     pin_src_t;

   // Index over X0, Y0, X1, Y1.
   typedef logic [$clog2(NUM_CLB_OUT)-1:0] pad_src_t;

   typedef logic [NUM_PAD_IN-1:0]          pad_in_t;
   typedef logic [NUM_PAD_OUT-1:0]         pad_out_t;

   typedef struct packed {
      logic a;
      logic b;
      logic c;
      logic d;
   } clb_pins_t;

   typedef struct packed {
      logic x;
      logic y;
   } clb_outs_t;

endpackage

// ==== rtl/cfg_pkg.sv ====
package cfg_pkg;

   import fabric_pkg::*;

   localparam int CFG_BITS = 100;

   typedef logic [15:0] lut_t;                          // Index {A,B,C,D}, A is the MSB.
   typedef logic [2:0]  pick_t;                         // Bit 2 A/B, bit 1 B/C, bit 0 C/DQ.
   typedef logic [1:0]  sel2_t;                         // 00 and 01 pick, 1x is the third.
   typedef logic [$clog2(CFG_BITS+1)-1:0] cfg_cnt_t;

   typedef enum logic [1:0] {
      comb_4in  = 2'b00,
      comb_two3 = 2'b01,
      comb_bsel = 2'b10
   } comb_mode_t;

   typedef struct packed {
      lut_t       lut;
      comb_mode_t comb_mode;
      pick_t      f_pick;
      pick_t      g_pick;
      logic       dq1_sel;                              // 0 D, 1 Q.
      logic       dq2_sel;
      sel2_t      s_sel;                                // A, F, 0.
      sel2_t      ce_sel;                               // G, C, always.
      sel2_t      r_sel;                                // D, G, 0.
      sel2_t      x_sel;                                // F, G, Q.
      sel2_t      y_sel;                                // Q, G, F.
   } clb_cfg_t;

   typedef struct packed {
      pin_src_t a;
      pin_src_t b;
      pin_src_t c;
      pin_src_t d;
   } route_cfg_t;

   typedef struct packed {
      clb_cfg_t   clb0;
      clb_cfg_t   clb1;
      route_cfg_t route0;
      route_cfg_t route1;
      pad_src_t   pad_sel0;
      pad_src_t   pad_sel1;
   } fabric_cfg_t;

endpackage

// ==== rtl/cfg_loader.sv ====
`timescale 1ns/1ps

module cfg_loader
   import cfg_pkg::*;
(
   input  logic        KLK,
   input  logic        arst_n,
   input  logic        cfg_start,
   input  logic        cfg_valid,
   input  logic        cfg_data,
   output fabric_cfg_t active_cfg,
   output logic        clb_clear,
   output logic        cfg_done
);

   logic [CFG_BITS-1:0] shadow;
   logic [CFG_BITS-1:0] shadow_next;
   cfg_cnt_t            bit_cnt;
   logic                take_bit;
   logic                last_bit;

   assign take_bit    = cfg_valid & ~cfg_done;          // Bits after the last are dropped.
   assign last_bit    = take_bit & (bit_cnt == cfg_cnt_t'(CFG_BITS - 1));
   assign shadow_next = {shadow[CFG_BITS-2:0], cfg_data};  // MSB first.

   // Blocks clear Q on the same edge as the configuration.
   assign clb_clear   = cfg_start;

   always_ff @(posedge KLK)
   begin
      if (cfg_start)
      begin
         shadow <= '0;
      end
      else if (take_bit)
      begin
         shadow <= shadow_next;
      end
   end

   always_ff @(posedge KLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         bit_cnt  <= '0;
         cfg_done <= 1'b0;
      end
      else if (cfg_start)
      begin
         bit_cnt  <= '0;
         cfg_done <= 1'b0;
      end
      else if (take_bit)
      begin
         bit_cnt  <= bit_cnt + 1'b1;
         cfg_done <= last_bit;
      end
   end

   always_ff @(posedge KLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         active_cfg <= '0;
      end
      else if (cfg_start)
      begin
         active_cfg <= '0;                              // Fabric idles while loading.
      end
      else if (last_bit)
      begin
         active_cfg <= fabric_cfg_t'(shadow_next);
      end
   end

endmodule

// ==== rtl/clb_cell.sv ====
`timescale 1ns/1ps

module clb_cell
   import fabric_pkg::*;
   import cfg_pkg::*;
(
   input  logic      KLK,
   input  logic      arst_n,
   input  clb_cfg_t  cfg,
   input  clb_pins_t pins,
   input  logic      clear,
   output clb_outs_t outs
);

   logic       q;
   logic       dq1;
   logic       dq2;
   logic [3:0] f_idx;
   logic [3:0] g_idx;
   logic       f;
   logic       g;
   logic       s;
   logic       r;
   logic       ce;

   function automatic logic pick3(sel2_t sel, logic in0, logic in1, logic in2);
      case (sel)
         2'b00:   return in0;
         2'b01:   return in1;
         default: return in2;
      endcase
   endfunction

   assign dq1 = cfg.dq1_sel ? q : pins.d;
   assign dq2 = cfg.dq2_sel ? q : pins.d;

   always_comb
   begin
      case (cfg.comb_mode)
         comb_4in:
         begin
            f_idx = {pins.a, pins.b, pins.c, dq1};
            g_idx = f_idx;
         end
         comb_two3:
         begin
            // Two 3-input functions, lower and upper half of the table.
            f_idx = {1'b0, cfg.f_pick[2] ? pins.b : pins.a,
                     cfg.f_pick[1] ? pins.c : pins.b, cfg.f_pick[0] ? dq1 : pins.c};
            g_idx = {1'b1, cfg.g_pick[2] ? pins.b : pins.a,
                     cfg.g_pick[1] ? pins.c : pins.b, cfg.g_pick[0] ? dq2 : pins.c};
         end
         default:
         begin
            f_idx = pins.b ? {1'b1, pins.a, pins.c, dq2} : {1'b0, pins.a, pins.c, dq1};
            g_idx = f_idx;                              // B picks the half.
         end
      endcase
   end

   assign f  = cfg.lut[f_idx];
   assign g  = cfg.lut[g_idx];

   assign s  = pick3(cfg.s_sel, pins.a, f, 1'b0);
   assign ce = pick3(cfg.ce_sel, g, pins.c, 1'b1);
   assign r  = pick3(cfg.r_sel, pins.d, g, 1'b0);

   always_ff @(posedge KLK or negedge arst_n)
   begin
      if (!arst_n)
         q <= 1'b0;
      else if (clear)
         q <= 1'b0;                                     // Reconfiguration start.
      else if (ce)
      begin
         if (r)
            q <= 1'b0;
         else if (s)
            q <= 1'b1;
         else
            q <= f;
      end
   end

   assign outs.x = pick3(cfg.x_sel, f, g, q);
   assign outs.y = pick3(cfg.y_sel, q, g, f);

endmodule

// ==== rtl/routing_matrix.sv ====
`timescale 1ns/1ps

module routing_matrix
   import fabric_pkg::*;
   import cfg_pkg::*;
(
   input  pad_in_t    pad_in,
   input  clb_outs_t  clb0_outs,
   input  clb_outs_t  clb1_outs,
   input  route_cfg_t route0,
   input  route_cfg_t route1,
   input  pad_src_t   pad_sel0,
   input  pad_src_t   pad_sel1,
   output clb_pins_t  clb0_pins,
   output clb_pins_t  clb1_pins,
   output pad_out_t   pad_out
);

   logic [NUM_CLB_OUT-1:0] clb_bits;
   logic [NUM_SRC-1:0]     src;

   function automatic clb_pins_t route_pins(route_cfg_t rt, logic [NUM_SRC-1:0] sv);
      clb_pins_t p;
      p.a = sv[rt.a];
      p.b = sv[rt.b];
      p.c = sv[rt.c];
      p.d = sv[rt.d];
      return p;
   endfunction

   // Bit 0 is X0, bit 3 is Y1.
   assign clb_bits = {clb1_outs.y, clb1_outs.x, clb0_outs.y, clb0_outs.x};

   assign src = {clb_bits, pad_in};                     // Pads at 0 to 3.

   assign clb0_pins = route_pins(route0, src);
   assign clb1_pins = route_pins(route1, src);

   assign pad_out[0] = clb_bits[pad_sel0];
   assign pad_out[1] = clb_bits[pad_sel1];

endmodule

// ==== rtl/fabric_top.sv ====
`timescale 1ns/1ps

module fabric_top
   import fabric_pkg::*;
   import cfg_pkg::*;
(
   input  logic     KLK,
   input  logic     arst_n,
   input  logic     cfg_start,
   input  logic     cfg_valid,
   input  logic     cfg_data,
   input  pad_in_t  pad_in,
   output pad_out_t pad_out,
   output logic     cfg_done
);

   fabric_cfg_t active_cfg;
   logic        clb_clear;
   clb_pins_t   clb0_pins;
   clb_pins_t   clb1_pins;
   clb_outs_t   clb0_outs;
   clb_outs_t   clb1_outs;

   cfg_loader u_loader (
      .KLK        (KLK),
      .arst_n     (arst_n),
      .cfg_start  (cfg_start),
      .cfg_valid  (cfg_valid),
      .cfg_data   (cfg_data),
      .active_cfg (active_cfg),
      .clb_clear  (clb_clear),
      .cfg_done   (cfg_done)
   );

   routing_matrix u_route (
      .pad_in    (pad_in),
      .clb0_outs (clb0_outs),
      .clb1_outs (clb1_outs),
      .route0    (active_cfg.route0),
      .route1    (active_cfg.route1),
      .pad_sel0  (active_cfg.pad_sel0),
      .pad_sel1  (active_cfg.pad_sel1),
      .clb0_pins (clb0_pins),
      .clb1_pins (clb1_pins),
      .pad_out   (pad_out)
   );

   clb_cell u_clb0 (
      .KLK    (KLK),
      .arst_n (arst_n),
      .cfg    (active_cfg.clb0),
      .pins   (clb0_pins),
      .clear  (clb_clear),
      .outs   (clb0_outs)
   );

   clb_cell u_clb1 (
      .KLK    (KLK),
      .arst_n (arst_n),
      .cfg    (active_cfg.clb1),
      .pins   (clb1_pins),
      .clear  (clb_clear),
      .outs   (clb1_outs)
   );

endmodule

// ==== verif/fabric_properties.sv ====
`timescale 1ns/1ps

module fabric_properties (
   input logic KLK,
   input logic arst_n,
   input logic clear,
   input logic level
);

   a_reset_low : assert property (@(posedge KLK) !arst_n |-> !level)
      else $error("cfg_done or Q not zero during reset");

   a_level_cleared : assert property (@(posedge KLK) disable iff (!arst_n)
      clear |=> !level)
      else $error("cfg_done or Q still high after clear");

   a_clear_pulse : assert property (@(posedge KLK) disable iff (!arst_n)
      $rose(clear) |=> !clear)
      else $error("clear pulse longer than one cycle");

endmodule

bind cfg_loader fabric_properties u_loader_props (
   .KLK(KLK), .arst_n(arst_n), .clear(clb_clear), .level(cfg_done)
);

bind clb_cell fabric_properties u_clb_props (
   .KLK(KLK), .arst_n(arst_n), .clear(clear), .level(q)
);

// ==== verif/tb_fabric.sv ====
`timescale 1ns/1ps

module tb_fabric
   import fabric_pkg::*;
   import cfg_pkg::*;
;

   localparam int NUM_CFG         = 4;
   localparam int MAX_VEC         = 40;
   localparam int NUM_VEC         = 16 + 16 + 40 + 10 + 10;  // Includes the pre-config pass.
   localparam int WATCHDOG_CYCLES = NUM_CFG * 110 + NUM_VEC * 2 + 50;

   logic     KLK;
   logic     arst_n;
   logic     cfg_start;
   logic     cfg_valid;
   logic     cfg_data;
   pad_in_t  pad_in;
   pad_out_t pad_out;
   logic     cfg_done;

   fabric_cfg_t cfg_tab [NUM_CFG];
   pad_in_t     stim_tab [NUM_CFG][MAX_VEC];
   int          n_vec [NUM_CFG];
   fabric_cfg_t model_cfg;
   logic        mq [2];                                 // Model Q of each block.
   logic        mq_next [2];
   int          errors;

   fabric_top UUT (
      .KLK       (KLK),
      .arst_n    (arst_n),
      .cfg_start (cfg_start),
      .cfg_valid (cfg_valid),
      .cfg_data  (cfg_data),
      .pad_in    (pad_in),
      .pad_out   (pad_out),
      .cfg_done  (cfg_done)
   );

   initial
   begin
      KLK = 1'b0;
      forever #2 KLK = ~KLK;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge KLK);
      $display("Watchdog expired: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
      $display("TESTS FAILED");
      $finish;
   end

   task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %0t: %s got %0h expected %0h", $time, msg, got, exp);
      end
   endtask

   function automatic logic sel3(input sel2_t sel, input logic i0, input logic i1,
                                 input logic i2);
      return (sel == 2'b00) ? i0 : ((sel == 2'b01) ? i1 : i2);
   endfunction

   // Logic block model from the mode, storage and output rules.
   task automatic clb_model(input clb_cfg_t c, input clb_pins_t p, input logic q,
                            output logic x, output logic y, output logic qn);
      logic       d1;
      logic       d2;
      logic       f;
      logic       g;
      logic       s;
      logic       r;
      logic       ce;
      logic [3:0] fi;
      logic [3:0] gi;
      d1 = c.dq1_sel ? q : p.d;
      d2 = c.dq2_sel ? q : p.d;
      if (c.comb_mode == comb_4in)
      begin
         fi = {p.a, p.b, p.c, d1};
         gi = fi;
      end
      else if (c.comb_mode == comb_two3)
      begin
         fi = {1'b0, c.f_pick[2] ? p.b : p.a, c.f_pick[1] ? p.c : p.b, c.f_pick[0] ? d1 : p.c};
         gi = {1'b1, c.g_pick[2] ? p.b : p.a, c.g_pick[1] ? p.c : p.b, c.g_pick[0] ? d2 : p.c};
      end
      else
      begin
         fi = p.b ? {1'b1, p.a, p.c, d2} : {1'b0, p.a, p.c, d1};
         gi = fi;
      end
      f  = c.lut[fi];
      g  = c.lut[gi];
      s  = sel3(c.s_sel, p.a, f, 1'b0);
      ce = sel3(c.ce_sel, g, p.c, 1'b1);
      r  = sel3(c.r_sel, p.d, g, 1'b0);
      qn = q;
      if (ce)
         qn = r ? 1'b0 : (s ? 1'b1 : f);
      x  = sel3(c.x_sel, f, g, q);
      y  = sel3(c.y_sel, q, g, f);
   endtask

   task automatic fabric_model(input fabric_cfg_t c, input pad_in_t p, output pad_out_t po);
      logic [7:0] src;
      logic [3:0] outs;
      clb_pins_t  p0;
      clb_pins_t  p1;
      logic       x0;
      logic       y0;
      logic       x1;
      logic       y1;
      logic       n0;
      logic       n1;
      outs = '0;
      for (int k = 0; k < 3; k++)                       // Settles any acyclic routing.
      begin
         src = {outs, p};
         p0  = {src[c.route0.a], src[c.route0.b], src[c.route0.c], src[c.route0.d]};
         p1  = {src[c.route1.a], src[c.route1.b], src[c.route1.c], src[c.route1.d]};
         clb_model(c.clb0, p0, mq[0], x0, y0, n0);
         clb_model(c.clb1, p1, mq[1], x1, y1, n1);
         outs = {y1, x1, y0, x0};
      end
      mq_next[0] = n0;
      mq_next[1] = n1;
      po = {outs[c.pad_sel1], outs[c.pad_sel0]};
   endtask

   // Entered and left on a falling edge.
   task automatic run_vectors(input int row, input logic done_exp);
      pad_out_t exp;
      for (int v = 0; v < n_vec[row]; v++)
      begin
         pad_in = stim_tab[row][v];
         #1;
         fabric_model(model_cfg, pad_in, exp);
         check_val(32'(cfg_done), 32'(done_exp), "cfg_done level");
         check_val(32'(pad_out), 32'(exp), $sformatf("pad_out row %0d vec %0d", row, v));
         mq[0] = mq_next[0];
         mq[1] = mq_next[1];
         @(negedge KLK);
      end
   endtask

   task automatic load_cfg(input fabric_cfg_t c, input bit gaps);
      logic [CFG_BITS-1:0] w;
      w         = c;
      cfg_start = 1'b1;
      cfg_valid = 1'b0;
      @(negedge KLK);
      cfg_start = 1'b0;
      model_cfg = '0;
      mq[0]     = 1'b0;
      mq[1]     = 1'b0;
      for (int i = CFG_BITS - 1; i >= 0; i--)
      begin
         if (gaps && (i % 7 == 3))
         begin
            cfg_valid = 1'b0;
            pad_in    = pad_in_t'($urandom);
            #1;
            check_val(32'(cfg_done), 0, "cfg_done in gap");
            check_val(32'(pad_out), 0, "pad_out while loading");
            @(negedge KLK);
         end
         cfg_valid = 1'b1;
         cfg_data  = w[i];                              // MSB first.
         pad_in    = pad_in_t'($urandom);
         #1;
         check_val(32'(cfg_done), 0, "cfg_done before last bit");
         check_val(32'(pad_out), 0, "pad_out while loading");
         @(negedge KLK);
      end
      cfg_valid = 1'b0;
      cfg_data  = 1'b0;
      model_cfg = c;
   endtask

   task automatic build_tables();
      fabric_cfg_t c;
      pad_in_t     seq [10];
      seq = '{4'b1101, 4'b0101, 4'b1000, 4'b0100, 4'b0110,
              4'b1000, 4'b1100, 4'b0010, 4'b0101, 4'b0000};
      // XOR of the pads into an AND with X0.
      c = '0;
      c.clb0.lut  = 16'h6996;
      c.clb1.lut  = 16'h8000;
      c.route0    = '{a: 3'd0, b: 3'd1, c: 3'd2, d: 3'd3};
      c.route1    = '{a: 3'd4, b: 3'd1, c: 3'd2, d: 3'd3};
      c.pad_sel1  = 2'd2;
      cfg_tab[0]  = c;
      c = '0;
      c.clb0.lut       = 16'ha5c3;
      c.clb0.comb_mode = comb_two3;
      c.clb0.f_pick    = 3'b101;
      c.clb0.g_pick    = 3'b010;
      c.clb0.dq1_sel   = 1'b1;
      c.clb0.s_sel     = 2'b10;
      c.clb0.ce_sel    = 2'b10;
      c.clb0.r_sel     = 2'b10;
      c.clb0.y_sel     = 2'b01;
      c.clb1.lut       = 16'h3e71;
      c.clb1.comb_mode = comb_bsel;
      c.clb1.dq2_sel   = 1'b1;
      c.clb1.s_sel     = 2'b01;
      c.clb1.x_sel     = 2'b10;
      c.clb1.y_sel     = 2'b10;
      c.route0   = '{a: 3'd3, b: 3'd0, c: 3'd1, d: 3'd2};
      c.route1   = '{a: 3'd4, b: 3'd2, c: 3'd5, d: 3'd0};
      c.pad_sel0 = 2'd3;
      c.pad_sel1 = 2'd2;
      cfg_tab[1] = c;
      // Enable from C, set from A, reset from D, F is B, Q on Y0.
      c = '0;
      c.clb0.lut    = 16'hf0f0;
      c.clb0.ce_sel = 2'b01;
      c.route0      = '{a: 3'd0, b: 3'd1, c: 3'd2, d: 3'd3};
      c.pad_sel0    = 2'd1;
      cfg_tab[2]    = c;
      // Same storage setup with F as the inverse of B.
      c.clb0.lut    = 16'h0f0f;
      cfg_tab[3]    = c;
      n_vec = '{16, 40, 10, 10};
      for (int v = 0; v < 16; v++)
         stim_tab[0][v] = pad_in_t'(v);
      for (int v = 0; v < 40; v++)
         stim_tab[1][v] = pad_in_t'($urandom);
      for (int v = 0; v < 10; v++)
      begin
         stim_tab[2][v] = seq[v];
         stim_tab[3][v] = seq[v];
      end
   endtask

   initial
   begin
      void'($urandom(32'hffd4_10ab));
      errors    = 0;
      arst_n    = 1'b0;
      cfg_start = 1'b0;
      cfg_valid = 1'b0;
      cfg_data  = 1'b0;
      pad_in    = '0;
      model_cfg = '0;
      mq[0]     = 1'b0;
      mq[1]     = 1'b0;
      build_tables();
      repeat (10) @(posedge KLK);
      @(negedge KLK);
      arst_n = 1'b1;
      run_vectors(0, 1'b0);                             // Unconfigured fabric.
      for (int k = 0; k < NUM_CFG; k++)
      begin
         load_cfg(cfg_tab[k], k == 0);
         run_vectors(k, 1'b1);
      end
      $display("Closing: %0d errors", errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== src.f ====
rtl/fabric_pkg.sv
rtl/cfg_pkg.sv
rtl/cfg_loader.sv
rtl/clb_cell.sv
rtl/routing_matrix.sv
rtl/fabric_top.sv
verif/fabric_properties.sv
verif/tb_fabric.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fabric testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   -f src.f \
   --top-module tb_fabric \
   -o sim_fabric

./obj_dir/sim_fabric | tee sim.log

grep -q "TESTS PASSED" sim.log
